/* all.f */
+incdir+.
axi_pkg.sv
cpu_pkg.sv
axi_master_port.sv
axi_rr_arbiter.sv
axi_sram_slave.sv
axi_subsystem_top.sv
axi_subsystem_properties.sv
tb_axi_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_axi_subsystem
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter %.sv,$(shell cat $(FILELIST))) axi_config.svh
EXE  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(EXE) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_axi_subsystem.sv */
`timescale 1ns/10ps
`include "axi_config.svh"

module tb_axi_subsystem
    import axi_pkg::*;
    import cpu_pkg::*;
();

    // About 300 operations at up to 10 cycles each, with margin
    localparam int MAX_CYCLES = 4000;

    logic      clk;
    logic      rst;
    cpu_req_t  cpu_req [`AXI_NUM_PORTS];
    cpu_rsp_t  cpu_rsp [`AXI_NUM_PORTS];
    axi_data_t ref_mem [`SRAM_WORDS];
    int        data_errs;
    int        stall_errs;
    int        assert_errs;
    int        cycles;
    integer    seed;

    axi_subsystem_top dut (
        .clk     (clk),
        .rst     (rst),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_data(input string name, input axi_data_t exp, input axi_data_t act);
        if (act !== exp) begin
            data_errs++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_stall(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stall_errs++;
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // Memory model, size rule applied to the low bytes of wdata
    task automatic model_write(input cpu_addr_t addr, input access_t size, input cpu_data_t wdata);
        int idx;
        int lane;
        idx  = int'(addr[11:2]);
        lane = int'(addr[1:0]);
        case (size)
            `CACHE_BYTE:  ref_mem[idx][8*lane +: 8] = wdata[7:0];
            `CACHE_HWORD: ref_mem[idx][16*(lane/2) +: 16] = wdata[15:0];
            default:      ref_mem[idx] = wdata;
        endcase
    endtask

    task automatic wait_stall_low(input int p);
        @(negedge clk);
        while (cpu_rsp[p].stall) @(negedge clk);
    endtask

    task automatic cpu_write(input int p, input cpu_addr_t addr, input access_t size,
                             input cpu_data_t value);
        model_write(addr, size, value);
        cpu_req[p].write      = 1'b1;
        cpu_req[p].write_type = size;
        cpu_req[p].addr       = addr;
        cpu_req[p].wdata      = value;
        wait_stall_low(p);
        cpu_req[p].write = 1'b0;
        // Bridge finishes B before the next request
        @(negedge clk);
    endtask

    task automatic read_check(input int p, input cpu_addr_t addr);
        axi_data_t got;
        cpu_req[p].read = 1'b1;
        cpu_req[p].addr = addr;
        wait_stall_low(p);
        got = cpu_rsp[p].rdata;
        cpu_req[p].read = 1'b0;
        check_data($sformatf("cpu_rsp[%0d].rdata", p), ref_mem[addr[11:2]], got);
        @(negedge clk);
    endtask

    task automatic idle_after_reset();
        for (int p = 0; p < `AXI_NUM_PORTS; p++) begin
            check_stall($sformatf("cpu_rsp[%0d].stall", p), 1'b0, cpu_rsp[p].stall);
        end
        @(negedge clk);
    endtask

    task automatic word_write_read();
        cpu_write(0, 32'h0000_0010, `CACHE_WORD, 32'hdead_beef);
        read_check(0, 32'h0000_0010);
        // Read data held once the request is gone
        check_data("cpu_rsp[0].rdata", ref_mem[4], cpu_rsp[0].rdata);
        check_stall("cpu_rsp[0].stall", 1'b0, cpu_rsp[0].stall);
    endtask

    task automatic lane_merge();
        cpu_write(0, 32'h0000_0020, `CACHE_WORD, 32'h1122_3344);
        for (int b = 0; b < 4; b++) begin
            cpu_write(b % 2, 32'h0000_0020 + b, `CACHE_BYTE, 32'h0000_00a0 + b);
            read_check(0, 32'h0000_0020);
        end
        cpu_write(1, 32'h0000_0022, `CACHE_HWORD, 32'h0000_5a6b);
        read_check(1, 32'h0000_0020);
        cpu_write(0, 32'h0000_0020, `CACHE_HWORD, 32'h0000_c3d4);
        read_check(0, 32'h0000_0020);
    endtask

    task automatic shared_memory();
        fork
            cpu_write(0, 32'h0000_0040, `CACHE_WORD, 32'h0a0a_5151);
            cpu_write(1, 32'h0000_0044, `CACHE_WORD, 32'h1b1b_6262);
            begin
                // Only one of the two can hold the link
                @(negedge clk);
                check_stall("stall_p0 ^ stall_p1", 1'b1,
                            cpu_rsp[0].stall ^ cpu_rsp[1].stall);
            end
        join
        fork
            read_check(1, 32'h0000_0040);
            read_check(0, 32'h0000_0044);
        join
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        cpu_addr_t   addr;
        access_t     size;
        int          p;
        // Known contents over the 8-word window first
        for (int w = 0; w < 8; w++) begin
            addr = 32'h0000_0100 + 4 * w;
            cpu_write(w % 2, addr, `CACHE_WORD, 32'h3c00_0000 ^ (addr * 32'h0001_0003));
        end
        repeat (200) begin
            r    = $random(seed);
            p    = int'(r[0]);
            addr = 32'h0000_0100 | {27'd0, r[5:1]};
            case (r[7:6])
                2'd0:    size = `CACHE_BYTE;
                2'd1:    size = `CACHE_HWORD;
                default: size = `CACHE_WORD;
            endcase
            if (size == `CACHE_HWORD) addr[0] = 1'b0;
            if (size == `CACHE_WORD) addr[1:0] = 2'b00;
            if (r[9]) begin
                read_check(p, addr);
            end else begin
                cpu_write(p, addr, size, $random(seed));
            end
        end
    endtask

    initial begin
        seed       = 25375;
        data_errs  = 0;
        stall_errs = 0;
        rst        = 1'b0;
        for (int p = 0; p < `AXI_NUM_PORTS; p++) begin
            cpu_req[p] = '0;
        end
        repeat (2) @(negedge clk);
        rst = 1'b1;
        idle_after_reset();
        word_write_read();
        lane_merge();
        shared_memory();
        random_traffic();
        assert_errs = dut.u_props.fail_count;
        $display("Errors: data %0d, stall %0d, assertion %0d",
                 data_errs, stall_errs, assert_errs);
        if (data_errs + stall_errs + assert_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* axi_subsystem_properties.sv */
`timescale 1ns/10ps
`include "axi_config.svh"

module axi_subsystem_properties
    import axi_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input axi_req_t s_req,
    input axi_rsp_t s_rsp
);

    int   fail_count;
    logic rd_open;
    logic wr_open;

    initial fail_count = 0;

    // Address accepted, response still owed
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_open <= 1'b0;
            wr_open <= 1'b0;
        end else begin
            if (s_req.ar.valid && s_rsp.arready) rd_open <= 1'b1;
            else if (s_rsp.r.valid && s_req.rready) rd_open <= 1'b0;
            if (s_req.aw.valid && s_rsp.awready) wr_open <= 1'b1;
            else if (s_rsp.b.valid && s_req.bready) wr_open <= 1'b0;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst)
        s_req.ar.valid && !s_rsp.arready |=> s_req.ar.valid)
        else begin
            fail_count++;
            $error("ARVALID dropped before ARREADY");
        end

    aw_hold: assert property (@(posedge clk) disable iff (!rst)
        s_req.aw.valid && !s_rsp.awready |=> s_req.aw.valid)
        else begin
            fail_count++;
            $error("AWVALID dropped before AWREADY");
        end

    w_hold: assert property (@(posedge clk) disable iff (!rst)
        s_req.w.valid && !s_rsp.wready |=> s_req.w.valid)
        else begin
            fail_count++;
            $error("WVALID dropped before WREADY");
        end

    r_hold: assert property (@(posedge clk) disable iff (!rst)
        s_rsp.r.valid && !s_req.rready |=> s_rsp.r.valid)
        else begin
            fail_count++;
            $error("RVALID dropped before RREADY");
        end

    b_hold: assert property (@(posedge clk) disable iff (!rst)
        s_rsp.b.valid && !s_req.bready |=> s_rsp.b.valid)
        else begin
            fail_count++;
            $error("BVALID dropped before BREADY");
        end

    r_after_ar: assert property (@(posedge clk) disable iff (!rst)
        s_rsp.r.valid |-> rd_open)
        else begin
            fail_count++;
            $error("R response without an AR handshake");
        end

    b_after_aw: assert property (@(posedge clk) disable iff (!rst)
        s_rsp.b.valid |-> wr_open)
        else begin
            fail_count++;
            $error("B response without an AW handshake");
        end

    one_dir: assert property (@(posedge clk) disable iff (!rst)
        !(s_req.ar.valid && s_req.aw.valid))
        else begin
            fail_count++;
            $error("AR and AW both valid on the shared link");
        end

endmodule

bind axi_subsystem_top axi_subsystem_properties u_props (
    .clk   (clk),
    .rst   (rst),
    .s_req (s_req),
    .s_rsp (s_rsp)
);

/* axi_subsystem_top.sv */
`timescale 1ns/10ps
`include "axi_config.svh"

module axi_subsystem_top
    import axi_pkg::*;
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  cpu_req_t cpu_req [`AXI_NUM_PORTS],
    output cpu_rsp_t cpu_rsp [`AXI_NUM_PORTS]
);

    axi_req_t m_req [`AXI_NUM_PORTS];
    axi_rsp_t m_rsp [`AXI_NUM_PORTS];
    axi_req_t s_req;
    axi_rsp_t s_rsp;

    // One bridge per CPU port
    for (genvar i = 0; i < `AXI_NUM_PORTS; i++) begin : g_port
        axi_master_port u_port (
            .clk     (clk),
            .rst     (rst),
            .cpu_req (cpu_req[i]),
            .cpu_rsp (cpu_rsp[i]),
            .axi_req (m_req[i]),
            .axi_rsp (m_rsp[i])
        );
    end

    axi_rr_arbiter u_arb (
        .clk   (clk),
        .rst   (rst),
        .m_req (m_req),
        .m_rsp (m_rsp),
        .s_req (s_req),
        .s_rsp (s_rsp)
    );

    axi_sram_slave u_sram (
        .clk   (clk),
        .rst   (rst),
        .s_req (s_req),
        .s_rsp (s_rsp)
    );

endmodule

/* axi_sram_slave.sv */
`timescale 1ns/10ps
`include "axi_config.svh"

module axi_sram_slave
    import axi_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  axi_req_t s_req,
    output axi_rsp_t s_rsp
);

    localparam int WA_BITS = $clog2(`SRAM_WORDS);

    typedef logic [WA_BITS-1:0] word_addr_t;

    typedef enum logic [1:0] {
        SL_IDLE,
        SL_RRESP,
        SL_WDATA,
        SL_WRESP
    } sl_state_t;

    sl_state_t  state_q;
    sl_state_t  state_d;
    axi_data_t  mem [`SRAM_WORDS];
    axi_data_t  rdata_q;
    axi_id_t    id_q;
    word_addr_t addr_q;
    logic       ar_done;
    logic       aw_done;
    logic       w_done;
    logic       b_done;
    logic       r_done;

    assign ar_done = s_req.ar.valid & s_rsp.arready;
    assign aw_done = s_req.aw.valid & s_rsp.awready;
    assign w_done  = s_req.w.valid & s_rsp.wready;
    assign b_done  = s_rsp.b.valid & s_req.bready;
    assign r_done  = s_rsp.r.valid & s_req.rready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            SL_IDLE: begin
                if (ar_done) begin
                    state_d = SL_RRESP;
                end else if (aw_done) begin
                    state_d = SL_WDATA;
                end
            end
            SL_RRESP: if (r_done) state_d = SL_IDLE;
            SL_WDATA: if (w_done) state_d = SL_WRESP;
            default:  if (b_done) state_d = SL_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= SL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Word index from address bits 11:2
    always_ff @(posedge clk) begin
        if (ar_done) begin
            id_q    <= s_req.ar.id;
            rdata_q <= mem[s_req.ar.addr[WA_BITS+1:2]];
        end else if (aw_done) begin
            id_q   <= s_req.aw.id;
            addr_q <= s_req.aw.addr[WA_BITS+1:2];
        end
        if (w_done) begin
            for (int b = 0; b < `AXI_STRB_BITS; b++) begin
                // Strobe bit low marks a written byte
                if (!s_req.w.strb[b]) begin
                    mem[addr_q][8*b +: 8] <= s_req.w.data[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        s_rsp         = '0;
        s_rsp.arready = (state_q == SL_IDLE);
        s_rsp.awready = (state_q == SL_IDLE);
        s_rsp.wready  = (state_q == SL_WDATA);
        s_rsp.b.valid = (state_q == SL_WRESP);
        s_rsp.b.id    = id_q;
        s_rsp.b.resp  = AXI_RESP_OKAY;
        s_rsp.r.valid = (state_q == SL_RRESP);
        s_rsp.r.id    = id_q;
        s_rsp.r.data  = rdata_q;
        s_rsp.r.resp  = AXI_RESP_OKAY;
        s_rsp.r.last  = 1'b1;
    end

endmodule

/* axi_rr_arbiter.sv */
`timescale 1ns/10ps
`include "axi_config.svh"

module axi_rr_arbiter
    import axi_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  axi_req_t m_req [`AXI_NUM_PORTS],
    output axi_rsp_t m_rsp [`AXI_NUM_PORTS],
    output axi_req_t s_req,
    input  axi_rsp_t s_rsp
);

    localparam int NP = `AXI_NUM_PORTS;
    localparam int IDX_BITS = (NP > 1) ? $clog2(NP) : 1;

    typedef logic [IDX_BITS-1:0] port_idx_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_READ,
        ARB_WRITE
    } arb_state_t;

    arb_state_t state_q;
    arb_state_t state_d;
    // Current grant while busy, last granted port while idle
    port_idx_t  grant_q;
    port_idx_t  sel;
    port_idx_t  cur;
    logic       found;
    logic       active;
    logic       is_read;

    // Search starts one past the last grant
    always_comb begin
        int idx;
        sel   = grant_q;
        found = 1'b0;
        for (int k = 1; k <= NP; k++) begin
            idx = (int'(grant_q) + k) % NP;
            if (!found && (m_req[idx].ar.valid || m_req[idx].aw.valid)) begin
                sel   = port_idx_t'(idx);
                found = 1'b1;
            end
        end
    end

    assign cur     = (state_q == ARB_IDLE) ? sel : grant_q;
    assign active  = (state_q != ARB_IDLE) || found;
    assign is_read = (state_q == ARB_IDLE) ? m_req[sel].ar.valid : (state_q == ARB_READ);

    always_comb begin
        s_req = '0;
        if (active) begin
            if (is_read) begin
                s_req.ar     = m_req[cur].ar;
                s_req.rready = m_req[cur].rready;
            end else begin
                s_req.aw     = m_req[cur].aw;
                s_req.w      = m_req[cur].w;
                s_req.bready = m_req[cur].bready;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NP; i++) begin
            m_rsp[i] = '0;
            if (active && cur == port_idx_t'(i)) begin
                if (is_read) begin
                    m_rsp[i].arready = s_rsp.arready;
                    m_rsp[i].r       = s_rsp.r;
                end else begin
                    m_rsp[i].awready = s_rsp.awready;
                    m_rsp[i].wready  = s_rsp.wready;
                    m_rsp[i].b       = s_rsp.b;
                end
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE:  if (found) state_d = is_read ? ARB_READ : ARB_WRITE;
            ARB_READ:  if (s_rsp.r.valid && s_req.rready) state_d = ARB_IDLE;
            ARB_WRITE: if (s_rsp.b.valid && s_req.bready) state_d = ARB_IDLE;
            default:   state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= ARB_IDLE;
            // Port 0 goes first
            grant_q <= port_idx_t'(NP - 1);
        end else begin
            state_q <= state_d;
            if (state_q == ARB_IDLE && found) begin
                grant_q <= sel;
            end
        end
    end

endmodule

/* axi_master_port.sv */
`timescale 1ns/10ps
`include "axi_config.svh"

module axi_master_port
    import axi_pkg::*;
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  cpu_req_t cpu_req,
    output cpu_rsp_t cpu_rsp,
    output axi_req_t axi_req,
    input  axi_rsp_t axi_rsp
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RADDR,
        ST_RDATA,
        ST_WADDR,
        ST_WDATA,
        ST_RESP
    } state_t;

    state_t    state_q;
    state_t    state_d;
    logic      armed;
    axi_data_t rdata_q;
    axi_strb_t strb;
    axi_data_t lane_data;
    logic      ar_done;
    logic      aw_done;
    logic      w_done;
    logic      b_done;
    logic      r_done;

    assign ar_done = axi_req.ar.valid & axi_rsp.arready;
    assign aw_done = axi_req.aw.valid & axi_rsp.awready;
    assign w_done  = axi_req.w.valid & axi_rsp.wready;
    assign b_done  = axi_rsp.b.valid & axi_req.bready;
    assign r_done  = axi_rsp.r.valid & axi_req.rready;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= ST_IDLE;
            armed   <= 1'b0;
        end else begin
            state_q <= state_d;
            // Blocks requests during the first cycle out of reset
            armed   <= 1'b1;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (axi_req.ar.valid) begin
                    state_d = ar_done ? ST_RDATA : ST_RADDR;
                end else if (axi_req.aw.valid) begin
                    state_d = aw_done ? ST_WDATA : ST_WADDR;
                end
            end
            ST_RADDR: if (ar_done) state_d = ST_RDATA;
            ST_RDATA: if (r_done) state_d = ST_IDLE;
            ST_WADDR: if (aw_done) state_d = ST_WDATA;
            ST_WDATA: if (w_done) state_d = ST_RESP;
            default:  if (b_done) state_d = ST_IDLE;
        endcase
    end

    // Active-low byte strobes from size and low address bits
    // Low bytes of wdata copied onto every lane
    always_comb begin
        strb      = '1;
        lane_data = cpu_req.wdata;
        case (cpu_req.write_type)
            `CACHE_BYTE: begin
                strb[cpu_req.addr[1:0]] = 1'b0;
                lane_data = {(`AXI_STRB_BITS){cpu_req.wdata[7:0]}};
            end
            `CACHE_HWORD: begin
                strb[{cpu_req.addr[1], 1'b0} +: 2] = 2'b00;
                lane_data = {(`AXI_STRB_BITS/2){cpu_req.wdata[15:0]}};
            end
            `CACHE_WORD:  strb = '0;
            default:      strb = '1;
        endcase
    end

    always_comb begin
        axi_req = '0;
        axi_req.ar.valid = (state_q == ST_IDLE) ? (cpu_req.read & armed)
                                                : (state_q == ST_RADDR);
        axi_req.ar.id    = '0;
        axi_req.ar.addr  = cpu_req.addr;
        axi_req.ar.len   = '0;
        axi_req.ar.size  = axi_size_t'(2);
        axi_req.ar.burst = `AXI_BURST_INC;
        // Read wins when both are held
        axi_req.aw.valid = (state_q == ST_IDLE)
                         ? (cpu_req.write & ~cpu_req.read & armed)
                         : (state_q == ST_WADDR);
        axi_req.aw.id    = '0;
        axi_req.aw.addr  = cpu_req.addr;
        axi_req.aw.len   = '0;
        axi_req.aw.size  = axi_size_t'(2);
        axi_req.aw.burst = `AXI_BURST_INC;
        axi_req.w.valid  = (state_q == ST_WDATA);
        axi_req.w.data   = lane_data;
        axi_req.w.strb   = strb;
        axi_req.w.last   = 1'b1;
        axi_req.bready   = (state_q == ST_RESP) | w_done;
        axi_req.rready   = (state_q == ST_RDATA);
    end

    always_ff @(posedge clk) begin
        if (r_done) begin
            rdata_q <= axi_rsp.r.data;
        end
    end

    assign cpu_rsp.rdata = r_done ? axi_rsp.r.data : rdata_q;
    assign cpu_rsp.stall = (cpu_req.read & ~r_done) | (cpu_req.write & ~w_done);

endmodule

/* cpu_pkg.sv */
`include "axi_config.svh"

package cpu_pkg;

    typedef logic [2:0]                access_t;
    typedef logic [`AXI_ADDR_BITS-1:0] cpu_addr_t;
    typedef logic [`AXI_DATA_BITS-1:0] cpu_data_t;

    // Held by the CPU until stall drops
    typedef struct packed {
        logic      read;
        logic      write;
        access_t   write_type;
        cpu_addr_t addr;
        cpu_data_t wdata;
    } cpu_req_t;

    typedef struct packed {
        cpu_data_t rdata;
        logic      stall;
    } cpu_rsp_t;

endpackage

/* axi_pkg.sv */
`include "axi_config.svh"

package axi_pkg;

    typedef logic [`AXI_ADDR_BITS-1:0] axi_addr_t;
    typedef logic [`AXI_DATA_BITS-1:0] axi_data_t;
    typedef logic [`AXI_STRB_BITS-1:0] axi_strb_t;
    typedef logic [`AXI_LEN_BITS-1:0]  axi_len_t;
    typedef logic [`AXI_SIZE_BITS-1:0] axi_size_t;
    typedef logic [`AXI_ID_BITS-1:0]   axi_id_t;
    typedef logic [1:0]                axi_resp_t;

    localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

    // Address channel, shared layout for reads and writes
    typedef struct packed {
        logic       valid;
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        logic [1:0] burst;
    } axi_ar_t;

    typedef axi_ar_t axi_aw_t;

    typedef struct packed {
        logic      valid;
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } axi_w_t;

    typedef struct packed {
        logic      valid;
        axi_id_t   id;
        axi_resp_t resp;
    } axi_b_t;

    typedef struct packed {
        logic      valid;
        axi_id_t   id;
        axi_data_t data;
        axi_resp_t resp;
        logic      last;
    } axi_r_t;

    // Master side of the link
    typedef struct packed {
        axi_ar_t ar;
        axi_aw_t aw;
        axi_w_t  w;
        logic    bready;
        logic    rready;
    } axi_req_t;

    // Slave side of the link
    typedef struct packed {
        logic   arready;
        logic   awready;
        logic   wready;
        axi_b_t b;
        axi_r_t r;
    } axi_rsp_t;

endpackage

/* axi_config.svh */
`ifndef AXI_CONFIG_SVH
`define AXI_CONFIG_SVH

// AXI link widths
`define AXI_ADDR_BITS 32
`define AXI_DATA_BITS 32
`define AXI_STRB_BITS 4
`define AXI_LEN_BITS  4
`define AXI_SIZE_BITS 3
`define AXI_ID_BITS   4

// INCR burst
`define AXI_BURST_INC 2'b01

// Subsystem size
`define AXI_NUM_PORTS 2
`define SRAM_WORDS    1024

// CPU access sizes
`define CACHE_BYTE  3'b000
`define CACHE_HWORD 3'b001
`define CACHE_WORD  3'b010

`endif
